// ==== src/cpuIsaPkg.sv ====
`default_nettype none

package cpuIsaPkg;

	localparam int DataWidth = 8;
	localparam int AddrWidth = 16;

	typedef logic [DataWidth-1:0] byteT;
	typedef logic [AddrWidth-1:0] wordT;

	////////////////////
	// Opcodes of the kept subset
	////////////////////
	localparam byteT OpNop    = 8'h00;
	localparam byteT OpLdBn   = 8'h06;
	localparam byteT OpLdCn   = 8'h0E;
	localparam byteT OpLdAn   = 8'h3E;
	localparam byteT OpLdHlnn = 8'h21;
	localparam byteT OpLdHlmA = 8'h77;
	localparam byteT OpLdHlmC = 8'h71;
	localparam byteT OpAddB   = 8'h80;
	localparam byteT OpSubB   = 8'h90;
	localparam byteT OpIncC   = 8'h0C;
	localparam byteT OpDecA   = 8'h3D;
	localparam byteT OpJr     = 8'h18;
	localparam byteT OpJrNz   = 8'h20;

	// Operand field of a micro-op
	typedef enum logic [3:0]
	{
		RegA, RegB, RegC, RegH, RegL,
		RegX8, RegX16, RegHl, RegPc, RegNull
	} regSelT;

endpackage

`default_nettype wire

// ==== src/ucodePkg.sv ====
`default_nettype none

package ucodePkg;

	import cpuIsaPkg::*;

	// What the sequencer does after the micro-op
	typedef enum logic [2:0]
	{
		ActOp,
		ActInc,
		ActEof,
		ActIncEof,
		ActIncEofZ,
		ActOpFlags
	} seqActT;

	typedef enum logic [3:0]
	{
		UopNop, UopSma, UopSmw, UopSrm,
		UopSx16r, UopSrx16, UopAddx16, UopSubx16,
		UopInc16, UopDec16, UopSpc
	} uopOpT;

	// Laid out as {action, operation, operand}
	typedef logic [10:0] uopWordT;
	typedef logic [5:0] flowIdxT;

	typedef enum logic [1:0] {FetchAddr, FetchWait, Decode, Execute} seqStateT;

	function automatic seqActT uopAct(uopWordT uop);
		return seqActT'(uop[10:8]);
	endfunction

	function automatic uopOpT uopOp(uopWordT uop);
		return uopOpT'(uop[7:4]);
	endfunction

	function automatic regSelT uopSel(uopWordT uop);
		return regSelT'(uop[3:0]);
	endfunction

endpackage

`default_nettype wire

// ==== src/uopBus.sv ====
`timescale 1ns/1ps
`default_nettype none

interface uopBus
	import cpuIsaPkg::*, ucodePkg::*;
();

	uopOpT op;
	regSelT operand;
	// Single-cycle strobes
	logic pcInc;
	logic flagWrite;
	logic zero;

	modport ctrl (output op, operand, pcInc, flagWrite, input zero);
	modport regs (input op, operand, pcInc);
	modport alu (input op, operand, flagWrite, output zero);

endinterface

`default_nettype wire

// ==== src/ucodeRom.sv ====
`timescale 1ns/1ps
`default_nettype none

module ucodeRom
	import cpuIsaPkg::*, ucodePkg::*;
(
	input wire byteT opcode,
	input wire flowIdxT uPc,
	output flowIdxT flowStart,
	output uopWordT uop
);

	////////////////////
	// Opcode lookup
	////////////////////
	always_comb
	begin
		case (opcode)
			OpNop:    flowStart = 6'd0;
			OpLdBn:   flowStart = 6'd1;
			OpLdCn:   flowStart = 6'd4;
			OpLdAn:   flowStart = 6'd7;
			OpLdHlnn: flowStart = 6'd10;
			OpLdHlmA: flowStart = 6'd14;
			OpLdHlmC: flowStart = 6'd17;
			OpAddB:   flowStart = 6'd20;
			OpSubB:   flowStart = 6'd23;
			OpIncC:   flowStart = 6'd26;
			OpDecA:   flowStart = 6'd29;
			OpJr:     flowStart = 6'd32;
			OpJrNz:   flowStart = 6'd38;
			// Unknown opcodes run as NOP
			default:  flowStart = 6'd0;
		endcase
	end

	////////////////////
	// Flows
	////////////////////
	always_comb
	begin
		case (uPc)
			6'd0:  uop = {ActIncEof, UopNop, RegNull};
			// LD r,n
			6'd1:  uop = {ActInc, UopSma, RegPc};
			6'd2:  uop = {ActInc, UopNop, RegNull};
			6'd3:  uop = {ActEof, UopSrm, RegB};
			6'd4:  uop = {ActInc, UopSma, RegPc};
			6'd5:  uop = {ActInc, UopNop, RegNull};
			6'd6:  uop = {ActEof, UopSrm, RegC};
			6'd7:  uop = {ActInc, UopSma, RegPc};
			6'd8:  uop = {ActInc, UopNop, RegNull};
			6'd9:  uop = {ActEof, UopSrm, RegA};
			// LD HL,nn, second Sma doubles as the wait for the first read
			6'd10: uop = {ActInc, UopSma, RegPc};
			6'd11: uop = {ActInc, UopSma, RegPc};
			6'd12: uop = {ActOp, UopSrm, RegL};
			6'd13: uop = {ActIncEof, UopSrm, RegH};
			// LD (HL),r
			6'd14: uop = {ActInc, UopSma, RegHl};
			6'd15: uop = {ActOp, UopSmw, RegA};
			6'd16: uop = {ActEof, UopSma, RegPc};
			6'd17: uop = {ActInc, UopSma, RegHl};
			6'd18: uop = {ActOp, UopSmw, RegC};
			6'd19: uop = {ActEof, UopSma, RegPc};
			// ADD A,B and SUB B through x16
			6'd20: uop = {ActOp, UopSx16r, RegA};
			6'd21: uop = {ActOpFlags, UopAddx16, RegB};
			6'd22: uop = {ActIncEof, UopSrx16, RegA};
			6'd23: uop = {ActOp, UopSx16r, RegA};
			6'd24: uop = {ActOpFlags, UopSubx16, RegB};
			6'd25: uop = {ActIncEof, UopSrx16, RegA};
			// INC C, DEC A
			6'd26: uop = {ActOp, UopSx16r, RegC};
			6'd27: uop = {ActOpFlags, UopInc16, RegX16};
			6'd28: uop = {ActIncEof, UopSrx16, RegC};
			6'd29: uop = {ActOp, UopSx16r, RegA};
			6'd30: uop = {ActOpFlags, UopDec16, RegX16};
			6'd31: uop = {ActIncEof, UopSrx16, RegA};
			// JR n, target is PC of next instruction plus signed x8
			6'd32: uop = {ActInc, UopSma, RegPc};
			6'd33: uop = {ActOp, UopNop, RegNull};
			6'd34: uop = {ActInc, UopSrm, RegX8};
			6'd35: uop = {ActOp, UopSx16r, RegPc};
			6'd36: uop = {ActOp, UopAddx16, RegX8};
			6'd37: uop = {ActEof, UopSpc, RegX16};
			// JR NZ,n leaves at 40 when Z is set
			6'd38: uop = {ActInc, UopSma, RegPc};
			6'd39: uop = {ActOp, UopNop, RegNull};
			6'd40: uop = {ActIncEofZ, UopSrm, RegX8};
			6'd41: uop = {ActOp, UopSx16r, RegPc};
			6'd42: uop = {ActOp, UopAddx16, RegX8};
			6'd43: uop = {ActEof, UopSpc, RegX16};
			default: uop = {ActEof, UopNop, RegNull};
		endcase
	end

endmodule

`default_nettype wire

// ==== src/ucodeSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ucodeSequencer
	import cpuIsaPkg::*, ucodePkg::*;
(
	input wire clk,
	input wire reset,
	input wire byteT memRdData,
	uopBus.ctrl bus
);

	seqStateT state;
	flowIdxT uPc;
	flowIdxT flowStart;
	uopWordT uop;
	seqActT act;
	logic endOfFlow;

	// Opcode byte is on the read port during Decode
	ucodeRom rom
	(
		.opcode(memRdData),
		.uPc(uPc),
		.flowStart(flowStart),
		.uop(uop)
	);

	assign act = uopAct(uop);

	always_comb
	begin
		case (act)
			ActEof, ActIncEof: endOfFlow = 1'b1;
			ActIncEofZ:        endOfFlow = bus.zero;
			default:           endOfFlow = 1'b0;
		endcase
	end

	////////////////////
	// Micro-op issue
	////////////////////
	always_comb
	begin
		bus.op = UopNop;
		bus.operand = RegNull;
		bus.pcInc = 1'b0;
		bus.flagWrite = 1'b0;
		case (state)
			FetchAddr:
			begin
				bus.op = UopSma;
				bus.operand = RegPc;
			end
			Execute:
			begin
				bus.op = uopOp(uop);
				bus.operand = uopSel(uop);
				bus.pcInc = act inside {ActInc, ActIncEof, ActIncEofZ};
				bus.flagWrite = (act == ActOpFlags);
			end
			default:
			begin
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= FetchAddr;
			uPc <= '0;
		end
		else
		begin
			case (state)
				FetchAddr: state <= FetchWait;
				FetchWait: state <= Decode;
				Decode:
				begin
					uPc <= flowStart;
					state <= Execute;
				end
				default:
				begin
					if (endOfFlow)
						state <= FetchAddr;
					else
						uPc <= uPc + 6'd1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile
	import cpuIsaPkg::*, ucodePkg::*;
#(
	parameter wordT ResetPc = '0
)
(
	input wire clk,
	input wire reset,
	uopBus.regs bus,
	input wire wordT x16,
	output wordT operandValue,
	input wire byteT memRdData,
	output wordT memAddr,
	output byteT memWrData,
	output logic memWrite
);

	byteT regA, regB, regC, regH, regL, regX8;
	wordT pc;
	wordT pcNext;
	byteT loadValue;

	assign pcNext = pc + wordT'(bus.pcInc);
	// Srm takes the read byte, Srx16 the low byte of x16
	assign loadValue = (bus.op == UopSrm) ? memRdData : x16[7:0];

	////////////////////
	// Operand select
	////////////////////
	always_comb
	begin
		case (bus.operand)
			RegA:    operandValue = {8'h00, regA};
			RegB:    operandValue = {8'h00, regB};
			RegC:    operandValue = {8'h00, regC};
			RegH:    operandValue = {8'h00, regH};
			RegL:    operandValue = {8'h00, regL};
			RegX8:   operandValue = {{8{regX8[7]}}, regX8};
			RegX16:  operandValue = x16;
			RegHl:   operandValue = {regH, regL};
			// Sma on PC with an Inc action addresses the next byte
			RegPc:   operandValue = pcNext;
			default: operandValue = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= ResetPc;
			memAddr <= ResetPc;
			memWrite <= 1'b0;
		end
		else
		begin
			pc <= (bus.op == UopSpc) ? operandValue : pcNext;
			if (bus.op == UopSma)
				memAddr <= operandValue;
			memWrite <= (bus.op == UopSmw);
		end
	end

	always_ff @(posedge clk)
	begin
		if (bus.op == UopSrm || bus.op == UopSrx16)
		begin
			case (bus.operand)
				RegA:  regA <= loadValue;
				RegB:  regB <= loadValue;
				RegC:  regC <= loadValue;
				RegH:  regH <= loadValue;
				RegL:  regL <= loadValue;
				RegX8: regX8 <= loadValue;
				RegHl:
				begin
					if (bus.op == UopSrx16)
						{regH, regL} <= x16;
				end
				default:
				begin
				end
			endcase
		end
		else if (bus.op == UopInc16 && bus.operand == RegHl)
			{regH, regL} <= {regH, regL} + 16'd1;
		else if (bus.op == UopDec16 && bus.operand == RegHl)
			{regH, regL} <= {regH, regL} - 16'd1;

		if (bus.op == UopSmw)
			memWrData <= operandValue[7:0];
	end

endmodule

`default_nettype wire

// ==== src/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit
	import cpuIsaPkg::*, ucodePkg::*;
(
	input wire clk,
	input wire reset,
	uopBus.alu bus,
	input wire wordT operandValue,
	output wordT x16
);

	localparam int ZeroBit = 1;
	localparam int CarryBit = 0;

	wordT result;
	logic resultWrite;
	logic [1:0] flags;

	always_comb
	begin
		result = x16;
		resultWrite = 1'b1;
		case (bus.op)
			UopAddx16: result = x16 + operandValue;
			UopSubx16: result = x16 - operandValue;
			// Inc16 and Dec16 on HL happen in the register file
			UopInc16:
			begin
				result = x16 + 16'd1;
				resultWrite = (bus.operand == RegX16);
			end
			UopDec16:
			begin
				result = x16 - 16'd1;
				resultWrite = (bus.operand == RegX16);
			end
			default: resultWrite = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (bus.op == UopSx16r)
			x16 <= operandValue;
		else if (resultWrite)
			x16 <= result;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else if (bus.flagWrite)
		begin
			flags[ZeroBit] <= (result[7:0] == 8'h00);
			// Byte operands sit zero-extended, so bit 8 is the carry or borrow
			flags[CarryBit] <= result[8];
		end
	end

	assign bus.zero = flags[ZeroBit];

endmodule

`default_nettype wire

// ==== src/dzCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module dzCore
	import cpuIsaPkg::*;
#(
	parameter wordT ResetPc = 16'h0000
)
(
	input wire clk,
	input wire reset,
	output wordT memAddr,
	output byteT memWrData,
	output logic memWrite,
	input wire byteT memRdData
);

	// Micro-op path, one per clock
	uopBus bus ();

	wordT operandValue;
	wordT x16;

	ucodeSequencer sequencer
	(
		.clk(clk),
		.reset(reset),
		.memRdData(memRdData),
		.bus(bus.ctrl)
	);

	regFile #(.ResetPc(ResetPc)) registers
	(
		.clk(clk),
		.reset(reset),
		.bus(bus.regs),
		.x16(x16),
		.operandValue(operandValue),
		.memRdData(memRdData),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.memWrite(memWrite)
	);

	aluUnit alu
	(
		.clk(clk),
		.reset(reset),
		.bus(bus.alu),
		.operandValue(operandValue),
		.x16(x16)
	);

endmodule

`default_nettype wire

// ==== testbench/dzCore_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module dzCore_checker
	import cpuIsaPkg::*;
(
	input wire clk,
	input wire reset,
	input wire wordT memAddr,
	input wire byteT memWrData,
	input wire memWrite
);

	// memWrite is only defined once the first reset edge has passed
	memWriteKnown: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(memWrite))
		else $error("memWrite is unknown after reset");

	// Stores are single-cycle strobes
	memWriteSingle: assert property (@(posedge clk) disable iff (reset)
		memWrite |=> !memWrite)
		else $error("memWrite stayed high for two cycles");

	memWriteDataKnown: assert property (@(posedge clk) disable iff (reset)
		memWrite |-> !$isunknown({memAddr, memWrData}))
		else $error("Memory write with unknown address or data");

endmodule

bind dzCore dzCore_checker memPortChecks
(
	.clk(clk),
	.reset(reset),
	.memAddr(memAddr),
	.memWrData(memWrData),
	.memWrite(memWrite)
);

`default_nettype wire

// ==== testbench/dzCore_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dzCore_tb
	import cpuIsaPkg::*;
();

	localparam wordT ResetPc = 16'h0000;
	localparam int unsigned Seed = 32'hfbfa_d9b4;
	localparam int SettleCycles = 40;
	// Loop test alone needs roughly 450 cycles at the largest count
	localparam int MaxCycles = 4000;

	logic clk;
	logic reset;
	wordT memAddr;
	byteT memWrData;
	logic memWrite;
	byteT memRdData;

	byteT mem [256];
	byteT readAddr;
	wordT writeAddr [$];
	byteT writeData [$];
	int loadPtr;
	int cycleCount;
	int errorCount;
	int testCount;

	dzCore #(.ResetPc(ResetPc)) u_dut
	(
		.clk(clk),
		.reset(reset),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.memWrite(memWrite),
		.memRdData(memRdData)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < MaxCycles)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d cycles", MaxCycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	////////////////////
	// Memory model
	////////////////////
	// Address taken on the rising edge, data shows on the next falling edge
	always @(posedge clk)
	begin
		readAddr <= memAddr[7:0];
		if (memWrite === 1'b1)
		begin
			mem[memAddr[7:0]] <= memWrData;
			writeAddr.push_back(memAddr);
			writeData.push_back(memWrData);
		end
	end

	always @(negedge clk)
		memRdData <= mem[readAddr];

	task automatic reportMismatch(input string testName, input string what,
		input logic [15:0] expected, input logic [15:0] actual);
		errorCount++;
		$display("Error %s %s: expected 0x%0h, actual 0x%0h", testName, what, expected, actual);
	endtask

	task automatic reportFailure(input string testName, input string what);
		errorCount++;
		$display("Error %s: %s", testName, what);
	endtask

	////////////////////
	// Program loading and reset
	////////////////////
	task automatic assertReset();
		int i;
		@(negedge clk);
		reset = 1'b1;
		writeAddr.delete();
		writeData.delete();
		for (i = 0; i < 256; i++)
			mem[i] = byteT'(i) ^ 8'hA5;
		loadPtr = 0;
		testCount++;
	endtask

	task automatic releaseReset(input string testName);
		repeat (4)
		begin
			@(negedge clk);
			if (memWrite !== 1'b0)
				reportFailure(testName, "memWrite was not low during reset");
		end
		reset = 1'b0;
	endtask

	task automatic putByte(input byteT value);
		mem[loadPtr[7:0]] = value;
		loadPtr++;
	endtask

	task automatic putLdHl(input wordT addr);
		putByte(OpLdHlnn);
		putByte(addr[7:0]);
		putByte(addr[15:8]);
	endtask

	// Offset -2 lands back on the JR opcode
	task automatic putJrSelf();
		putByte(OpJr);
		putByte(8'hFE);
	endtask

	function automatic byteT randomByte();
		return byteT'($urandom());
	endfunction

	// Upper half of the memory, clear of every program
	function automatic wordT randomStoreAddr();
		return {byteT'($urandom()), 1'b1, 7'($urandom())};
	endfunction

	task automatic waitForWrites(input string testName, input int count);
		while (writeAddr.size() < count)
			@(negedge clk);
		repeat (SettleCycles) @(negedge clk);
		if (writeAddr.size() != count)
			reportMismatch(testName, "write count", count, writeAddr.size());
	endtask

	task automatic checkWrite(input string testName, input int index,
		input wordT expAddr, input byteT expData);
		if (index >= writeAddr.size())
			reportFailure(testName, $sformatf("write %0d never happened", index));
		else
		begin
			if (writeAddr[index] !== expAddr)
				reportMismatch(testName, $sformatf("write %0d address", index),
					expAddr, writeAddr[index]);
			if (writeData[index] !== expData)
				reportMismatch(testName, $sformatf("write %0d data", index),
					expData, writeData[index]);
		end
	endtask

	////////////////////
	// Directed tests
	////////////////////
	task automatic testReset();
		assertReset();
		putJrSelf();
		releaseReset("reset");
		if (memAddr !== ResetPc)
			reportMismatch("reset", "memAddr after reset", ResetPc, memAddr);
		@(negedge clk);
		if (memAddr !== ResetPc)
			reportMismatch("reset", "first fetch address", ResetPc, memAddr);
		waitForWrites("reset", 0);
	endtask

	task automatic testLoadStore();
		byteT valueA;
		byteT valueC;
		wordT hl;
		valueA = randomByte();
		valueC = randomByte();
		hl = randomStoreAddr();
		assertReset();
		putByte(OpLdAn);
		putByte(valueA);
		putByte(OpLdCn);
		putByte(valueC);
		putLdHl(hl);
		putByte(OpLdHlmA);
		putByte(OpLdHlmC);
		putJrSelf();
		releaseReset("loadStore");
		waitForWrites("loadStore", 2);
		checkWrite("loadStore", 0, hl, valueA);
		checkWrite("loadStore", 1, hl, valueC);
	endtask

	task automatic testArithmetic();
		byteT valueA;
		byteT valueB;
		byteT sum;
		byteT diff;
		wordT hl;
		valueA = randomByte();
		valueB = randomByte();
		hl = randomStoreAddr();
		sum = byteT'(valueA + valueB);
		diff = byteT'(sum - valueB);
		assertReset();
		putByte(OpLdAn);
		putByte(valueA);
		putByte(OpLdBn);
		putByte(valueB);
		putByte(OpAddB);
		putLdHl(hl);
		putByte(OpLdHlmA);
		putByte(OpSubB);
		putByte(OpLdHlmA);
		putJrSelf();
		releaseReset("arithmetic");
		waitForWrites("arithmetic", 2);
		checkWrite("arithmetic", 0, hl, sum);
		checkWrite("arithmetic", 1, hl, diff);
	endtask

	task automatic testIncDec();
		wordT hl;
		hl = randomStoreAddr();
		assertReset();
		putByte(OpLdCn);
		putByte(8'hFF);
		putByte(OpIncC);
		putByte(OpLdAn);
		putByte(8'h00);
		putByte(OpDecA);
		putLdHl(hl);
		putByte(OpLdHlmC);
		putByte(OpLdHlmA);
		putJrSelf();
		releaseReset("incDec");
		waitForWrites("incDec", 2);
		checkWrite("incDec", 0, hl, 8'h00);
		checkWrite("incDec", 1, hl, 8'hFF);
	endtask

	task automatic testLoop();
		byteT count;
		wordT hl;
		int loopStart;
		count = byteT'($urandom_range(20, 1));
		hl = randomStoreAddr();
		assertReset();
		putByte(OpLdAn);
		putByte(count);
		putByte(OpLdCn);
		putByte(8'h00);
		loopStart = loadPtr;
		putByte(OpIncC);
		putByte(OpDecA);
		putByte(OpJrNz);
		// Relative to the address after the offset byte
		putByte(byteT'(loopStart - (loadPtr + 1)));
		putLdHl(hl);
		putByte(OpLdHlmC);
		putJrSelf();
		releaseReset("loop");
		waitForWrites("loop", 1);
		checkWrite("loop", 0, hl, count);
	endtask

	task automatic testJump();
		byteT valueA;
		byteT valueC;
		wordT firstAddr;
		wordT secondAddr;
		valueA = randomByte();
		valueC = randomByte();
		firstAddr = randomStoreAddr();
		secondAddr = firstAddr ^ 16'h0001;
		assertReset();
		putByte(OpLdAn);
		putByte(valueA);
		putByte(OpLdCn);
		putByte(valueC);
		putLdHl(firstAddr);
		putByte(OpLdHlmA);
		putByte(OpJr);
		putByte(8'h01);
		// Skipped store
		putByte(OpLdHlmC);
		putLdHl(secondAddr);
		putByte(OpLdHlmC);
		putJrSelf();
		releaseReset("jump");
		waitForWrites("jump", 2);
		checkWrite("jump", 0, firstAddr, valueA);
		checkWrite("jump", 1, secondAddr, valueC);
	endtask

	initial
	begin
		reset = 1'b1;
		memRdData = '0;
		readAddr = '0;
		loadPtr = 0;
		errorCount = 0;
		testCount = 0;
		void'($urandom(Seed));
		testReset();
		testLoadStore();
		testArithmetic();
		testIncDec();
		testLoop();
		testJump();
		$display("Tests run: %0d, errors: %0d", testCount, errorCount);
		if (errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/cpuIsaPkg.sv
src/ucodePkg.sv
src/uopBus.sv
src/ucodeRom.sv
src/ucodeSequencer.sv
src/regFile.sv
src/aluUnit.sv
src/dzCore.sv
testbench/dzCore_checker.sv
testbench/dzCore_tb.sv

// ==== Bender.yml ====
package:
  name: dz_core

sources:
  - src/cpuIsaPkg.sv
  - src/ucodePkg.sv
  - src/uopBus.sv
  - src/ucodeRom.sv
  - src/ucodeSequencer.sv
  - src/regFile.sv
  - src/aluUnit.sv
  - src/dzCore.sv
  - target: test
    files:
      - testbench/dzCore_checker.sv
      - testbench/dzCore_tb.sv
